/* build.f */
source/aud_pkg.sv
source/sram_pkg.sv
source/aud_recorder.sv
source/aud_player.sv
source/sram_arbiter.sv
source/aud_top.sv
tests/tb_clock.sv
tests/sram_model.sv
tests/tb_aud_top.sv

/* source/aud_pkg.sv */
package aud_pkg;

    localparam int SAMPLE_W = 16;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [4:0]          bitcnt_t;  // 0 to SAMPLE_W inclusive

    typedef enum logic [2:0] {
        s_idle,
        s_wait,   // armed, waits for a frame start
        s_rec,
        s_pause,
        s_finish
    } rec_state_t;

    typedef enum logic [2:0] {
        p_idle,
        p_rise,   // waits for lrc to go high, then fetches
        p_req,
        p_data,
        p_fall,   // word held, waits for the low half
        p_shift
    } ply_state_t;

endpackage

/* source/aud_player.sv */
module aud_player (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_lrc,
    input  logic             i_play,
    input  logic             i_stop,
    input  sram_pkg::addr_t  i_rec_len,
    input  logic             i_rd_gnt,
    input  aud_pkg::sample_t i_rd_data,
    output logic             o_rd_req,
    output sram_pkg::addr_t  o_rd_addr,
    output logic             o_dac_data,
    output logic             o_playing
);

    aud_pkg::ply_state_t state_r, state_w;
    sram_pkg::addr_t     addr_r, addr_w;
    aud_pkg::sample_t    word_r, word_w;     // doubles as the shift register
    aud_pkg::bitcnt_t    cnt_r, cnt_w;
    logic                rd_req_r, rd_req_w;
    logic                dac_r, dac_w;
    logic                lrc_d;

    assign o_rd_req   = rd_req_r;
    assign o_rd_addr  = addr_r;
    assign o_dac_data = dac_r;
    assign o_playing  = (state_r != aud_pkg::p_idle);

    always_comb begin
        state_w  = state_r;
        addr_w   = addr_r;
        word_w   = word_r;
        cnt_w    = cnt_r;
        rd_req_w = rd_req_r;
        dac_w    = dac_r;

        case (state_r)
            aud_pkg::p_idle: begin
                if (i_play) begin
                    addr_w  = '0;
                    state_w = aud_pkg::p_rise;
                end
            end
            aud_pkg::p_rise: begin
                if (i_lrc && !lrc_d) begin
                    // the recorder has written this frame's word by now
                    if (addr_r >= i_rec_len) begin
                        state_w = aud_pkg::p_idle;
                    end else begin
                        rd_req_w = 1'b1;
                        state_w  = aud_pkg::p_req;
                    end
                end
            end
            aud_pkg::p_req: begin
                if (i_rd_gnt) begin
                    rd_req_w = 1'b0;
                    addr_w   = addr_r + 1'b1;
                    state_w  = aud_pkg::p_data;
                end
            end
            aud_pkg::p_data: begin
                word_w  = i_rd_data;         // valid the cycle after the grant
                state_w = aud_pkg::p_fall;
            end
            aud_pkg::p_fall: begin
                if (!i_lrc && lrc_d) begin
                    dac_w   = word_r[aud_pkg::SAMPLE_W-1];
                    word_w  = word_r << 1;
                    cnt_w   = 5'd1;
                    state_w = aud_pkg::p_shift;
                end
            end
            aud_pkg::p_shift: begin
                if (cnt_r == aud_pkg::SAMPLE_W) begin
                    dac_w   = 1'b0;          // line idles low after the last bit
                    cnt_w   = '0;
                    state_w = aud_pkg::p_rise;
                end else begin
                    dac_w  = word_r[aud_pkg::SAMPLE_W-1];
                    word_w = word_r << 1;
                    cnt_w  = cnt_r + 1'b1;
                end
            end
            default: begin
                state_w = aud_pkg::p_idle;
            end
        endcase

        if (i_stop) begin
            state_w  = aud_pkg::p_idle;
            rd_req_w = 1'b0;
            dac_w    = 1'b0;
            cnt_w    = '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r  <= aud_pkg::p_idle;
            addr_r   <= '0;
            cnt_r    <= '0;
            rd_req_r <= 1'b0;
            dac_r    <= 1'b0;
            lrc_d    <= 1'b0;
        end else begin
            state_r  <= state_w;
            addr_r   <= addr_w;
            cnt_r    <= cnt_w;
            rd_req_r <= rd_req_w;
            dac_r    <= dac_w;
            lrc_d    <= i_lrc;
        end
    end

    always_ff @(posedge i_clk) begin
        word_r <= word_w;
    end

endmodule

/* source/aud_recorder.sv */
module aud_recorder #(
    parameter sram_pkg::addr_t MAX_WORDS = 20'd1024000
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_lrc,
    input  logic             i_start,
    input  logic             i_pause,
    input  logic             i_stop,
    input  logic             i_data,
    input  logic             i_wr_gnt,
    output logic             o_wr_req,
    output sram_pkg::addr_t  o_wr_addr,
    output aud_pkg::sample_t o_wr_data,
    output sram_pkg::addr_t  o_rec_len,
    output logic             o_rec_done
);

    aud_pkg::rec_state_t state_r, state_w;
    sram_pkg::addr_t     addr_r, addr_w;
    aud_pkg::sample_t    data_r, data_w;
    aud_pkg::bitcnt_t    cnt_r, cnt_w;
    logic                wr_req_r, wr_req_w;
    logic                lrc_d;
    logic                frame_start;
    logic                full;

    assign frame_start = !i_lrc && lrc_d;        // first low cycle after a high half
    assign full        = (addr_r == MAX_WORDS);

    assign o_wr_req   = wr_req_r;
    assign o_wr_addr  = addr_r;
    assign o_wr_data  = data_r;                  // held until the next frame starts
    assign o_rec_len  = addr_r;                  // words written so far
    assign o_rec_done = (state_r == aud_pkg::s_finish);

    always_comb begin
        state_w  = state_r;
        addr_w   = addr_r;
        data_w   = data_r;
        cnt_w    = cnt_r;
        wr_req_w = wr_req_r;

        // the pending write finishes whatever the FSM does meanwhile
        if (wr_req_r && i_wr_gnt) begin
            wr_req_w = 1'b0;
            addr_w   = addr_r + 1'b1;
        end

        // i_pause is a one-cycle pulse, each pulse toggles pause
        case (state_r)
            aud_pkg::s_idle: begin
                if (i_start) begin
                    cnt_w   = '0;
                    state_w = aud_pkg::s_wait;
                end
            end
            aud_pkg::s_wait: begin
                if (i_stop || full) begin
                    state_w = aud_pkg::s_finish;
                end else if (i_pause) begin
                    state_w = aud_pkg::s_pause;
                end else if (frame_start) begin
                    data_w[aud_pkg::SAMPLE_W-1] = i_data;  // MSB first
                    cnt_w   = 5'd1;
                    state_w = aud_pkg::s_rec;
                end
            end
            aud_pkg::s_rec: begin
                if (i_stop || full) begin
                    cnt_w   = '0;
                    state_w = aud_pkg::s_finish;
                end else if (i_pause) begin
                    cnt_w   = '0;                // partial frame is dropped
                    state_w = aud_pkg::s_pause;
                end else if (i_lrc) begin
                    cnt_w   = '0;                // short frame, wait for the next one
                    state_w = aud_pkg::s_wait;
                end else begin
                    data_w[aud_pkg::SAMPLE_W-1-cnt_r] = i_data;
                    cnt_w = cnt_r + 1'b1;
                    if (cnt_r == aud_pkg::SAMPLE_W - 1) begin
                        wr_req_w = 1'b1;
                        state_w  = aud_pkg::s_wait;
                    end
                end
            end
            aud_pkg::s_pause: begin
                if (i_stop || full) begin
                    state_w = aud_pkg::s_finish;
                end else if (i_pause) begin
                    state_w = aud_pkg::s_wait;   // resume on the next frame start
                end
            end
            aud_pkg::s_finish: begin
                state_w = aud_pkg::s_idle;
            end
            default: begin
                state_w = aud_pkg::s_idle;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r  <= aud_pkg::s_idle;
            addr_r   <= '0;
            cnt_r    <= '0;
            wr_req_r <= 1'b0;
            lrc_d    <= 1'b0;
        end else begin
            state_r  <= state_w;
            addr_r   <= addr_w;
            cnt_r    <= cnt_w;
            wr_req_r <= wr_req_w;
            lrc_d    <= i_lrc;
        end
    end

    always_ff @(posedge i_clk) begin
        data_r <= data_w;
    end

endmodule

/* source/aud_top.sv */
module aud_top #(
    parameter sram_pkg::addr_t MAX_WORDS = 20'd1024000
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_lrc,
    input  logic            i_adc_data,
    input  logic            i_rec_start,
    input  logic            i_rec_pause,
    input  logic            i_rec_stop,
    input  logic            i_play,
    input  logic            i_play_stop,
    input  sram_pkg::data_t i_sram_rdata,
    output sram_pkg::addr_t o_sram_addr,
    output logic            o_sram_we_n,
    output logic            o_sram_oe_n,
    output sram_pkg::data_t o_sram_wdata,
    output logic            o_dac_data,
    output logic            o_rec_done,
    output logic            o_playing
);

    logic             rec_wr_req;
    logic             rec_wr_gnt;
    sram_pkg::addr_t  rec_wr_addr;
    aud_pkg::sample_t rec_wr_data;
    sram_pkg::addr_t  rec_len;
    logic             ply_rd_req;
    logic             ply_rd_gnt;
    sram_pkg::addr_t  ply_rd_addr;
    aud_pkg::sample_t ply_rd_data;

    aud_recorder #(
        .MAX_WORDS (MAX_WORDS)
    ) u_recorder (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lrc      (i_lrc),
        .i_start    (i_rec_start),
        .i_pause    (i_rec_pause),
        .i_stop     (i_rec_stop),
        .i_data     (i_adc_data),
        .i_wr_gnt   (rec_wr_gnt),
        .o_wr_req   (rec_wr_req),
        .o_wr_addr  (rec_wr_addr),
        .o_wr_data  (rec_wr_data),
        .o_rec_len  (rec_len),
        .o_rec_done (o_rec_done)
    );

    aud_player u_player (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lrc      (i_lrc),
        .i_play     (i_play),
        .i_stop     (i_play_stop),
        .i_rec_len  (rec_len),
        .i_rd_gnt   (ply_rd_gnt),
        .i_rd_data  (ply_rd_data),
        .o_rd_req   (ply_rd_req),
        .o_rd_addr  (ply_rd_addr),
        .o_dac_data (o_dac_data),
        .o_playing  (o_playing)
    );

    sram_arbiter u_arbiter (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_wr_req     (rec_wr_req),
        .i_wr_addr    (rec_wr_addr),
        .i_wr_data    (rec_wr_data),
        .i_rd_req     (ply_rd_req),
        .i_rd_addr    (ply_rd_addr),
        .i_sram_rdata (i_sram_rdata),
        .o_wr_gnt     (rec_wr_gnt),
        .o_rd_gnt     (ply_rd_gnt),
        .o_rd_data    (ply_rd_data),
        .o_sram_addr  (o_sram_addr),
        .o_sram_we_n  (o_sram_we_n),
        .o_sram_oe_n  (o_sram_oe_n),
        .o_sram_wdata (o_sram_wdata)
    );

endmodule

/* source/sram_arbiter.sv */
module sram_arbiter (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_wr_req,
    input  sram_pkg::addr_t  i_wr_addr,
    input  aud_pkg::sample_t i_wr_data,
    input  logic             i_rd_req,
    input  sram_pkg::addr_t  i_rd_addr,
    input  sram_pkg::data_t  i_sram_rdata,
    output logic             o_wr_gnt,
    output logic             o_rd_gnt,
    output aud_pkg::sample_t o_rd_data,
    output sram_pkg::addr_t  o_sram_addr,
    output logic             o_sram_we_n,
    output logic             o_sram_oe_n,
    output sram_pkg::data_t  o_sram_wdata
);

    logic wr_gnt;
    logic rd_gnt;
    logic turn_r;                           // bus turnaround cycle after a read

    // writes win, except right after a read while the data bus turns around
    assign wr_gnt = i_wr_req && !turn_r;
    assign rd_gnt = i_rd_req && !i_wr_req;

    assign o_wr_gnt = wr_gnt;
    assign o_rd_gnt = rd_gnt;

    assign o_sram_addr  = wr_gnt ? i_wr_addr : i_rd_addr;
    assign o_sram_we_n  = !wr_gnt;
    assign o_sram_oe_n  = !rd_gnt;
    assign o_sram_wdata = i_wr_data;

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            turn_r <= 1'b0;
        end else begin
            turn_r <= rd_gnt;
        end
    end

    // async sram, data is settled by the end of the grant cycle
    always_ff @(posedge i_clk) begin
        if (rd_gnt) begin
            o_rd_data <= i_sram_rdata;
        end
    end

endmodule

/* source/sram_pkg.sv */
package sram_pkg;

    localparam int ADDR_W = 20;
    localparam int DATA_W = 16;

    // word address, one 16-bit word per location
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

endpackage

/* tests/sram_model.sv */
module sram_model #(
    parameter int DEPTH = 64
) (
    input  logic            i_clk,
    input  sram_pkg::addr_t i_addr,
    input  logic            i_we_n,
    input  logic            i_oe_n,
    input  sram_pkg::data_t i_wdata,
    output sram_pkg::data_t o_rdata
);

    sram_pkg::data_t mem [0:DEPTH-1];
    sram_pkg::addr_t log_addr [0:DEPTH-1];   // addresses in write order
    int              log_cnt = 0;

    assign o_rdata = i_oe_n ? 'z : mem[i_addr];

    // write pulse taken mid-cycle where address and data have settled
    always @(negedge i_clk) begin
        if (!i_we_n) begin
            if (i_addr < DEPTH) begin
                mem[i_addr] = i_wdata;
            end
            if (log_cnt < DEPTH) begin
                log_addr[log_cnt] = i_addr;
            end
            log_cnt++;
        end
    end

endmodule

/* tests/tb_aud_top.sv */
module tb_aud_top;

    localparam int FRAME_CYCLES  = 40;
    localparam int WATCHDOG_TIME = 6 * 12 * FRAME_CYCLES * 8 + 4000;

    logic clk, rst_n, rst_req;
    logic lrc, adc;
    logic rec_start, rec_pause, rec_stop, play, play_stop;
    sram_pkg::data_t sram_rdata, sram_wdata;
    sram_pkg::addr_t sram_addr;
    logic sram_we_n, sram_oe_n;
    logic dac, rec_done, playing;

    logic [31:0]      lfsr_state = 32'he6d4;
    aud_pkg::sample_t ref_mem [0:63];     // expected word at each address
    sram_pkg::addr_t  next_addr;          // next write address per the recorder rules
    int errs = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int done_cnt = 0;
    int done_writes = 0;

    tb_clock #(.PERIOD(8), .RST_CYCLES(16)) u_clock (
        .i_rst_req (rst_req),
        .o_clk     (clk),
        .o_rst_n   (rst_n)
    );

    sram_model #(.DEPTH(64)) u_sram (
        .i_clk   (clk),
        .i_addr  (sram_addr),
        .i_we_n  (sram_we_n),
        .i_oe_n  (sram_oe_n),
        .i_wdata (sram_wdata),
        .o_rdata (sram_rdata)
    );

    aud_top #(.MAX_WORDS(20'd8)) dut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_lrc        (lrc),
        .i_adc_data   (adc),
        .i_rec_start  (rec_start),
        .i_rec_pause  (rec_pause),
        .i_rec_stop   (rec_stop),
        .i_play       (play),
        .i_play_stop  (play_stop),
        .i_sram_rdata (sram_rdata),
        .o_sram_addr  (sram_addr),
        .o_sram_we_n  (sram_we_n),
        .o_sram_oe_n  (sram_oe_n),
        .o_sram_wdata (sram_wdata),
        .o_dac_data   (dac),
        .o_rec_done   (rec_done),
        .o_playing    (playing)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function logic take_random_bit();
        take_random_bit = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
    endfunction

    task automatic check_sample(input string what, input aud_pkg::sample_t exp,
                                input aud_pkg::sample_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, got %h", what, exp, act);
            errs++;
        end
    endtask

    task automatic check_addr(input string what, input sram_pkg::addr_t exp,
                              input sram_pkg::addr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %0d, got %0d", what, exp, act);
            errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %b, got %b", what, exp, act);
            errs++;
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        tests_run++;
        if (errs == e0) begin
            $display("%-22s passed", name);
        end else begin
            tests_failed++;
            $display("%-22s failed with %0d errors", name, errs - e0);
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst_req = 1'b1;
        @(negedge clk);
        rst_req = 1'b0;
        wait (!rst_n);
        @(negedge clk);
    endtask

    task automatic pulse_controls(input logic start, input logic pause, input logic stop,
                                  input logic ply, input logic ply_stop);
        @(negedge clk);
        rec_start = start;
        rec_pause = pause;
        rec_stop  = stop;
        play      = ply;
        play_stop = ply_stop;
        @(negedge clk);
        rec_start = 1'b0;
        rec_pause = 1'b0;
        rec_stop  = 1'b0;
        play      = 1'b0;
        play_stop = 1'b0;
    endtask

    // one codec frame: 20 cycles low with 16 ADC bits, then 20 cycles high
    task automatic run_frame(output aud_pkg::sample_t sent, output aud_pkg::sample_t heard);
        int i;
        sent  = '0;
        heard = '0;
        for (i = 0; i < FRAME_CYCLES / 2; i++) begin
            @(negedge clk);
            if (i >= 1 && i <= 16) begin
                heard[16 - i] = dac;            // dac bit set on the previous rising edge
            end
            lrc = 1'b0;
            if (i < 16) begin
                sent[15 - i] = take_random_bit();
                adc = sent[15 - i];
            end else begin
                adc = 1'b0;
            end
        end
        for (i = 0; i < FRAME_CYCLES / 2; i++) begin
            @(negedge clk);
            lrc = 1'b1;
            adc = 1'b0;
        end
    endtask

    task automatic store_frame(output aud_pkg::sample_t heard);
        aud_pkg::sample_t sent;
        run_frame(sent, heard);
        ref_mem[next_addr] = sent;
        next_addr = next_addr + 1'b1;
    endtask

    task automatic wait_rec_done(input string name);
        int n;
        n = 0;
        while (!rec_done && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (!rec_done) begin
            $display("%s: o_rec_done did not pulse within 40 cycles of the stop", name);
            errs++;
        end
    endtask

    task automatic check_writes(input string name, input int log0, input int n,
                                input sram_pkg::addr_t base);
        int k;
        sram_pkg::addr_t a;
        check_addr({name, " write count"}, sram_pkg::addr_t'(n),
                   sram_pkg::addr_t'(u_sram.log_cnt - log0));
        for (k = 0; k < n; k++) begin
            a = base + sram_pkg::addr_t'(k);
            check_addr({name, " write address"}, a, u_sram.log_addr[log0 + k]);
            check_sample({name, " stored word"}, ref_mem[a], u_sram.mem[a]);
        end
    endtask

    task automatic reset_values();
        int e0;
        e0 = errs;
        check_bit("reset o_sram_we_n", 1'b1, sram_we_n);
        check_bit("reset o_sram_oe_n", 1'b1, sram_oe_n);
        check_bit("reset o_dac_data", 1'b0, dac);
        check_bit("reset o_rec_done", 1'b0, rec_done);
        check_bit("reset o_playing", 1'b0, playing);
        finish_test("reset values", e0);
    endtask

    task automatic record_stop();
        int e0;
        int log0;
        sram_pkg::addr_t base;
        aud_pkg::sample_t heard;
        e0   = errs;
        log0 = u_sram.log_cnt;
        base = next_addr;
        pulse_controls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (3) store_frame(heard);
        pulse_controls(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        wait_rec_done("record and stop");
        check_writes("record and stop", log0, 3, base);
        finish_test("record and stop", e0);
    endtask

    task automatic playback();
        int e0;
        int k;
        aud_pkg::sample_t sent, heard;
        e0 = errs;
        pulse_controls(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        run_frame(sent, heard);                 // first word is fetched in this high half
        check_sample("playback idle line", '0, heard);
        for (k = 0; k < 3; k++) begin
            if (k == 2) begin
                check_bit("playback o_playing before last word", 1'b1, playing);
            end
            run_frame(sent, heard);
            check_sample("playback word", ref_mem[k], heard);
        end
        check_bit("playback o_playing at end", 1'b0, playing);
        finish_test("playback", e0);
    endtask

    task automatic pause_resume();
        int e0;
        int log0;
        sram_pkg::addr_t base;
        aud_pkg::sample_t sent, heard;
        e0   = errs;
        log0 = u_sram.log_cnt;
        base = next_addr;
        pulse_controls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        store_frame(heard);
        pulse_controls(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        repeat (2) run_frame(sent, heard);      // discarded while paused
        pulse_controls(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        repeat (2) store_frame(heard);
        pulse_controls(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        wait_rec_done("pause and resume");
        check_writes("pause and resume", log0, 3, base);
        finish_test("pause and resume", e0);
    endtask

    task automatic full_memory();
        int e0;
        int log0;
        int d0;
        int k;
        aud_pkg::sample_t sent, heard;
        reset_dut();
        e0        = errs;
        next_addr = '0;
        log0      = u_sram.log_cnt;
        d0        = done_cnt;
        pulse_controls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        for (k = 0; k < 10; k++) begin
            if (k < 8) begin
                store_frame(heard);
            end else begin
                run_frame(sent, heard);
            end
        end
        check_writes("full memory", log0, 8, '0);
        check_addr("full memory o_rec_done pulses", 20'd1, sram_pkg::addr_t'(done_cnt - d0));
        check_addr("full memory writes before done", 20'd8,
                   sram_pkg::addr_t'(done_writes - log0));
        finish_test("full memory", e0);
    endtask

    task automatic record_while_playing();
        int e0;
        int log0;
        int k;
        sram_pkg::addr_t base;
        aud_pkg::sample_t heard;
        reset_dut();
        e0        = errs;
        next_addr = '0;
        pulse_controls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (2) store_frame(heard);
        pulse_controls(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        wait_rec_done("record while playing");
        log0 = u_sram.log_cnt;
        base = next_addr;
        pulse_controls(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        for (k = 0; k < 4; k++) begin
            store_frame(heard);
            if (k > 0) begin
                check_sample("record while playing dac word", ref_mem[k - 1], heard);
            end
        end
        pulse_controls(1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
        wait_rec_done("record while playing");
        check_writes("record while playing", log0, 4, base);
        check_bit("record while playing o_playing", 1'b0, playing);
        finish_test("record while playing", e0);
    endtask

    always @(negedge clk) begin
        if (rec_done) begin
            done_cnt++;
            done_writes = u_sram.log_cnt;
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog: the run did not finish in %0d time units", WATCHDOG_TIME);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst_req   = 1'b0;
        lrc       = 1'b1;                       // idles high between frames
        adc       = 1'b0;
        rec_start = 1'b0;
        rec_pause = 1'b0;
        rec_stop  = 1'b0;
        play      = 1'b0;
        play_stop = 1'b0;
        next_addr = '0;
        wait (!rst_n);
        @(negedge clk);
        reset_values();
        record_stop();
        playback();
        pause_resume();
        full_memory();
        record_while_playing();
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errs);
        if (errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 16
) (
    input  logic i_rst_req,
    output logic o_clk,
    output logic o_rst_n
);

    int rst_cnt = RST_CYCLES;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // a request restarts the reset window
    always @(posedge o_clk) begin
        if (i_rst_req) begin
            rst_cnt <= RST_CYCLES;
        end else if (rst_cnt > 0) begin
            rst_cnt <= rst_cnt - 1;
        end
    end

    assign o_rst_n = (rst_cnt != 0);    // active high

endmodule
